//--- Bender.yml
package:
  name: noc_error_port

sources:
  - logic/noc_pkg.sv
  - logic/flit_slice.sv
  - logic/error_request_sink.sv
  - logic/error_response_gen.sv
  - logic/dest_error_checker.sv
  - logic/noc_error_port.sv
  - target: test
    files:
      - bench/tb_noc_error_port.sv

//--- bench/tb_noc_error_port.sv
`timescale 1ns/1ps
`default_nettype none

module tb_noc_error_port import noc_pkg::*; ();

  localparam int size_x = 4;
  localparam int size_y = 4;
  localparam logic [31:0] error_data = 32'hdead_beef;
  localparam int rows = 14;
  localparam int passes = 3;
  localparam int timed_rows = 7;
  localparam int drain_cycles = 100;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      in_valid;
  logic      in_ready;
  noc_flit_t in_flit;
  logic      out_valid;
  logic      out_ready;
  noc_flit_t out_flit;

  int          cycle = 0;
  logic        random_ready = 1'b0;
  logic [34:0] exp_q[$];
  logic [34:0] next_exp;
  int          accept_q[$];

  // Nibbles are invalid bit, type, dest x, dest y, src x, src y, tag, burst and payload flits
  logic [35:0] packets [rows] = '{
    36'h0_1_1_2_0_0_1_4_0,
    36'h0_2_2_1_1_1_2_3_3,
    36'h0_3_0_3_2_2_3_2_2,
    36'h0_4_3_0_1_0_4_0_0,
    36'h0_5_1_1_3_3_5_2_2,
    36'h0_2_3_3_0_1_6_1_1,  // far corner of the mesh
    36'h0_1_0_3_2_1_7_1_0,
    // Rows 7 to 12 are misrouted
    36'h0_1_4_0_1_2_8_3_0,
    36'h0_1_0_4_2_3_9_1_0,
    36'h1_1_2_2_3_1_a_2_0,
    36'h0_3_5_1_0_2_b_2_2,
    36'h0_2_1_7_2_0_c_3_3,  // posted so nothing comes back
    36'h0_3_1_4_3_2_d_1_1,
    36'h0_5_2_3_0_0_e_f_f
  };

  noc_error_port #(
    .size_x     (size_x),
    .size_y     (size_y),
    .error_data (error_data)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_flit   (in_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_flit  (out_flit)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    out_ready <= random_ready ? ($urandom % 4 != 0) : 1'b1;
  end

  function automatic noc_flit_t packet_flit(input int row, input int pass, input int idx);
    noc_flit_t   f;
    noc_header_t h;
    h                     = '0;
    h.packet_type         = packet_type_e'(packets[row][30:28]);
    h.dest_x              = packets[row][26:24];
    h.dest_y              = packets[row][22:20];
    h.src_x               = packets[row][18:16];
    h.src_y               = packets[row][14:12];
    h.tag                 = packets[row][11:8];
    h.burst_length        = packets[row][7:4];
    h.invalid_destination = packets[row][32];
    f.head = idx == 0;
    f.tail = idx == int'(packets[row][3:0]);
    if (idx == 0) begin
      f.body.header = h;
    end else begin
      f.body.data = {8'h5a, 8'(pass), 8'(row), 8'(idx)};
    end
    return f;
  endfunction

  // Reference model with bit 34 of each entry marking a flit whose latency is checked
  task automatic expect_packet(input int row, input int pass, input logic timed);
    noc_flit_t   head;
    noc_header_t req;
    noc_header_t resp;
    head        = packet_flit(row, pass, 0);
    req         = head.body.header;
    resp        = '0;
    resp.dest_x = req.src_x;
    resp.dest_y = req.src_y;
    resp.src_x  = req.dest_x;
    resp.src_y  = req.dest_y;
    resp.tag    = req.tag;
    resp.status = status_decode_error;
    if (!req.invalid_destination && int'(req.dest_x) < size_x &&
        int'(req.dest_y) < size_y) begin
      for (int i = 0; i <= int'(packets[row][3:0]); i++) begin
        exp_q.push_back({timed, packet_flit(row, pass, i)});
      end
    end else if (req.packet_type == packet_read) begin
      resp.packet_type  = packet_response_data;
      resp.burst_length = req.burst_length;
      exp_q.push_back({1'b0, 1'b1, 1'b0, resp});
      for (int i = 1; i <= int'(req.burst_length); i++) begin
        exp_q.push_back({1'b0, 1'b0, i == int'(req.burst_length), error_data});
      end
    end else if (req.packet_type == packet_write_np) begin
      resp.packet_type = packet_response;
      exp_q.push_back({1'b0, 1'b1, 1'b1, resp});
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                             input string what);
    if (got !== expected) begin
      abort_run($sformatf("MISMATCH at %0t ns: %s, got %h, expected %h",
                          $time, what, got, expected));
    end
  endtask

  task automatic send_flit(input noc_flit_t f, input logic timed, input int gap);
    if (gap > 0) begin
      in_valid <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    in_valid <= 1'b1;
    in_flit  <= f;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
    if (timed) begin
      accept_q.push_back(cycle);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        abort_run("A flit left the DUT when none was expected");
      end else begin
        next_exp = exp_q.pop_front();
        check_value(64'(out_flit), 64'(next_exp[33:0]), "out_flit");
        if (next_exp[34]) begin
          check_value(64'(cycle - accept_q.pop_front()), 64'd2, "cycles from in to out");
        end
      end
    end
  end

  initial begin
    int flits;
    flits = 0;
    for (int r = 0; r < rows; r++) begin
      flits += 1 + int'(packets[r][3:0]);
    end
    #(40 * flits * passes + 200);
    abort_run("Timeout, the DUT stopped moving flits");
  end

  initial begin
    int gap;
    int waited;
    void'($urandom(32'h92a0));
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_flit   = '0;
    out_ready = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // Later passes run the table again under random back-pressure
    for (int p = 0; p < passes; p++) begin
      random_ready <= (p > 0);
      for (int r = 0; r < rows; r++) begin
        expect_packet(r, p, p == 0 && r < timed_rows);
        for (int i = 0; i <= int'(packets[r][3:0]); i++) begin
          gap = (p > 0 && $urandom % 3 == 0) ? 1 : 0;
          send_flit(packet_flit(r, p, i), p == 0 && r < timed_rows, gap);
        end
      end
      in_valid <= 1'b0;
      waited = 0;
      while (exp_q.size() != 0 && waited < drain_cycles) begin
        @(posedge clk);
        waited++;
      end
    end
    repeat (20) @(posedge clk);
    if (exp_q.size() != 0 || accept_q.size() != 0) begin
      abort_run("Expected flits were left over at the end of the run");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- logic/dest_error_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dest_error_checker import noc_pkg::*; #(
  parameter int          size_x     = 4,
  parameter int          size_y     = 4,
  parameter logic [31:0] error_data = 32'hdead_beef
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  output logic      in_ready,
  input  noc_flit_t in_flit,
  output logic      out_valid,
  input  logic      out_ready,
  output noc_flit_t out_flit
);

  noc_header_t in_header;
  logic        head_invalid;
  logic        start_of_packet;
  logic        route_error;
  logic        route_error_q;
  logic        draining;
  logic        in_move;

  logic        req_valid;
  logic        req_ready;
  logic        req_done;
  logic        req_respond;
  noc_header_t req_header;

  logic        resp_busy;
  logic        resp_valid;
  logic        resp_ready;
  noc_flit_t   resp_flit;

  logic        slice_valid;
  logic        slice_ready;
  noc_flit_t   slice_flit;

  assign in_header    = in_flit.body.header;
  assign head_invalid = in_header.invalid_destination ||
                        (int'(in_header.dest_x) >= size_x) ||
                        (int'(in_header.dest_y) >= size_y);

  assign start_of_packet = in_valid && in_flit.head && !draining && !resp_busy;
  assign route_error     = start_of_packet ? head_invalid : route_error_q;
  assign in_move         = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      route_error_q <= 1'b0;
    end else if (start_of_packet) begin
      route_error_q <= head_invalid;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      draining <= 1'b0;
    end else if (req_done) begin
      draining <= 1'b0;
    end else if (in_move && route_error && in_flit.head) begin
      draining <= 1'b1;
    end
  end

  // Input side steering, closed while a response goes out
  assign req_valid = in_valid && !resp_busy && route_error;
  assign in_ready  = !resp_busy && (route_error ? req_ready : slice_ready);

  // Response replaces the request in the output stream
  assign slice_valid = resp_busy ? resp_valid : (in_valid && !route_error);
  assign slice_flit  = resp_busy ? resp_flit : in_flit;
  assign resp_ready  = resp_busy && slice_ready;

  error_request_sink u_request_sink (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_flit    (in_flit),
    .req_done    (req_done),
    .req_respond (req_respond),
    .req_header  (req_header)
  );

  error_response_gen #(
    .error_data (error_data)
  ) u_response_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_done    (req_done),
    .req_respond (req_respond),
    .req_header  (req_header),
    .resp_busy   (resp_busy),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .resp_flit   (resp_flit)
  );

  flit_slice u_out_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (slice_valid),
    .in_ready  (slice_ready),
    .in_flit   (slice_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_flit  (out_flit)
  );

endmodule

`default_nettype wire

//--- logic/error_request_sink.sv
`timescale 1ns/1ps
`default_nettype none

module error_request_sink import noc_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_valid,
  output logic        req_ready,
  input  noc_flit_t   req_flit,
  output logic        req_done,
  output logic        req_respond,
  output noc_header_t req_header
);

  logic        flit_move;
  logic        head_move;
  logic        in_packet;
  noc_header_t header_q;

  // A misrouted packet is drained at full rate
  assign req_ready = 1'b1;

  assign flit_move = req_valid && req_ready;
  assign head_move = flit_move && req_flit.head;
  assign req_done  = flit_move && req_flit.tail && (in_packet || req_flit.head);

  // Single-flit packets report before the header lands in the register
  assign req_header  = head_move ? req_flit.body.header : header_q;
  assign req_respond = req_done && needs_response(req_header.packet_type);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_packet <= 1'b0;
    end else if (flit_move) begin
      if (req_flit.tail) begin
        in_packet <= 1'b0;
      end else if (req_flit.head) begin
        in_packet <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (head_move) begin
      header_q <= req_flit.body.header;
    end
  end

endmodule

`default_nettype wire

//--- logic/error_response_gen.sv
`timescale 1ns/1ps
`default_nettype none

module error_response_gen import noc_pkg::*; #(
  parameter logic [31:0] error_data = 32'hdead_beef
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_done,
  input  logic        req_respond,
  input  noc_header_t req_header,
  output logic        resp_busy,
  output logic        resp_valid,
  input  logic        resp_ready,
  output noc_flit_t   resp_flit
);

  localparam logic [1:0] st_idle   = 2'd0;
  localparam logic [1:0] st_skip   = 2'd1;
  localparam logic [1:0] st_header = 2'd2;
  localparam logic [1:0] st_data   = 2'd3;

  logic [1:0]         state;
  logic [burst_w-1:0] payload_count;
  logic               resp_move;
  logic               resp_has_data;
  logic               last_data;
  noc_header_t        resp_header;

  assign resp_move     = resp_valid && resp_ready;
  assign resp_has_data = req_header.packet_type == packet_read;
  assign last_data     = payload_count == burst_w'(1);

  // Skip state holds the input closed one cycle when nothing is owed
  assign resp_busy  = state != st_idle;
  assign resp_valid = (state == st_header) || (state == st_data);

  always_comb begin
    resp_header              = '0;
    resp_header.packet_type  = resp_has_data ? packet_response_data : packet_response;
    resp_header.dest_x       = req_header.src_x;
    resp_header.dest_y       = req_header.src_y;
    resp_header.src_x        = req_header.dest_x;
    resp_header.src_y        = req_header.dest_y;
    resp_header.tag          = req_header.tag;
    resp_header.burst_length = resp_has_data ? req_header.burst_length : '0;
    resp_header.status       = status_decode_error;
  end

  always_comb begin
    resp_flit = '0;
    if (state == st_header) begin
      resp_flit.head        = 1'b1;
      resp_flit.tail        = !resp_has_data;
      resp_flit.body.header = resp_header;
    end else begin
      resp_flit.tail      = last_data;
      resp_flit.body.data = error_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (req_done) begin
            state <= req_respond ? st_header : st_skip;
          end
        end
        st_skip:   state <= st_idle;
        st_header: begin
          if (resp_move) begin
            state <= resp_has_data ? st_data : st_idle;
          end
        end
        default: begin
          if (resp_move && last_data) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      payload_count <= '0;
    end else if (resp_move && (state == st_header)) begin
      payload_count <= resp_has_data ? req_header.burst_length : '0;
    end else if (resp_move) begin
      payload_count <= payload_count - burst_w'(1);
    end
  end

endmodule

`default_nettype wire

//--- logic/flit_slice.sv
`timescale 1ns/1ps
`default_nettype none

module flit_slice import noc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  output logic      in_ready,
  input  noc_flit_t in_flit,
  output logic      out_valid,
  input  logic      out_ready,
  output noc_flit_t out_flit
);

  logic      main_valid;
  logic      skid_valid;
  noc_flit_t main_flit;
  noc_flit_t skid_flit;
  logic      in_move;
  logic      main_free;

  assign in_move   = in_valid && in_ready;
  assign main_free = !main_valid || out_ready;

  // Ready comes straight from the skid flop
  assign in_ready  = !skid_valid;
  assign out_valid = main_valid;
  assign out_flit  = main_flit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      if (skid_valid) begin
        main_valid <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        main_valid <= in_move;
      end
    end else if (in_move) begin
      // Output stalled, park the incoming flit
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free && skid_valid) begin
      main_flit <= skid_flit;
    end else if (main_free && in_move) begin
      main_flit <= in_flit;
    end
    if (!main_free && in_move) begin
      skid_flit <= in_flit;
    end
  end

endmodule

`default_nettype wire

//--- logic/noc_error_port.sv
`timescale 1ns/1ps
`default_nettype none

module noc_error_port import noc_pkg::*; #(
  parameter int          size_x     = 4,
  parameter int          size_y     = 4,
  parameter logic [31:0] error_data = 32'hdead_beef
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  output logic      in_ready,
  input  noc_flit_t in_flit,
  output logic      out_valid,
  input  logic      out_ready,
  output noc_flit_t out_flit
);

  logic      ingress_valid;
  logic      ingress_ready;
  noc_flit_t ingress_flit;

  flit_slice u_ingress_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_flit   (in_flit),
    .out_valid (ingress_valid),
    .out_ready (ingress_ready),
    .out_flit  (ingress_flit)
  );

  dest_error_checker #(
    .size_x     (size_x),
    .size_y     (size_y),
    .error_data (error_data)
  ) u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (ingress_valid),
    .in_ready  (ingress_ready),
    .in_flit   (ingress_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_flit  (out_flit)
  );

endmodule

`default_nettype wire

//--- logic/noc_pkg.sv
`default_nettype none

package noc_pkg;

  // Mesh coordinates, up to 8 by 8 nodes
  localparam int coord_w = 3;
  localparam int data_w = 32;
  localparam int tag_w = 4;
  localparam int burst_w = 4;

  typedef enum logic [2:0] {
    packet_invalid       = 3'd0,
    packet_read          = 3'd1,
    packet_write         = 3'd2,
    packet_write_np      = 3'd3,
    packet_response      = 3'd4,
    packet_response_data = 3'd5
  } packet_type_e;

  typedef enum logic [1:0] {
    status_ok           = 2'd0,
    status_decode_error = 2'd1
  } status_e;

  typedef struct packed {
    packet_type_e         packet_type;
    logic [coord_w-1:0]   dest_x;
    logic [coord_w-1:0]   dest_y;
    logic [coord_w-1:0]   src_x;
    logic [coord_w-1:0]   src_y;
    logic [tag_w-1:0]     tag;
    // Number of data flits; for a read, the number requested
    logic [burst_w-1:0]   burst_length;
    status_e              status;
    logic                 invalid_destination;
    logic [5:0]           spare;
  } noc_header_t;

  // Head flits read the body as a header, all others as data
  typedef union packed {
    noc_header_t         header;
    logic [data_w-1:0]   data;
  } flit_body_u;

  typedef struct packed {
    logic       head;
    logic       tail;
    flit_body_u body;
  } noc_flit_t;

  function automatic logic needs_response(input packet_type_e packet_type);
    logic result;
    case (packet_type)
      packet_read,
      packet_write_np: result = 1'b1;
      default:         result = 1'b0;
    endcase
    return result;
  endfunction

  function automatic logic carries_payload(input packet_type_e packet_type);
    logic result;
    case (packet_type)
      packet_write,
      packet_write_np,
      packet_response_data: result = 1'b1;
      default:              result = 1'b0;
    endcase
    return result;
  endfunction

endpackage

`default_nettype wire

//--- noc_error_port.f
logic/noc_pkg.sv
logic/flit_slice.sv
logic/error_request_sink.sv
logic/error_response_gen.sv
logic/dest_error_checker.sv
logic/noc_error_port.sv
bench/tb_noc_error_port.sv
